//--- overlay_macros.svh
`ifndef OVERLAY_MACROS_SVH
`define OVERLAY_MACROS_SVH

// Bus widths
`define COORD_W    10
`define CHAR_W     7
`define ROW_W      4
`define ROM_ADDR_W 11        // Character code then font row
`define COLOR_W    3

`define BLANK_CHAR 7'h0A     // Code sent with every background pixel

// Glyphs are 8 columns wide and units follow tens directly
`define GLYPH_W      10'd8
`define PAIR_GLYPHS  10'd2
`define LABEL_GLYPHS 10'd6

`define TIME_Y_TOP 10'd240
`define TIME_Y_BOT 10'd255
`define HOURS_X    10'd295
`define MINUTES_X  10'd319
`define SECONDS_X  10'd342

`define WEEK_Y_TOP 10'd16
`define WEEK_Y_BOT 10'd31
`define LABEL_X    10'd287   // "SEMANA"
`define WEEKNUM_X  10'd343

`define YEAR_Y_TOP 10'd418
`define YEAR_Y_BOT 10'd433
`define PREFIX_X   10'd583   // Fixed "20"
`define YEAR_X     10'd599

`define DAY_Y_TOP  10'd434
`define DAY_Y_BOT  10'd449
`define DAY_X      10'd591

`define DATE_Y_TOP 10'd450   // Weekday and month share this row
`define DATE_Y_BOT 10'd465
`define WEEKDAY_X  10'd575
`define MONTH_X    10'd607

// Last row of each background band, top to bottom
`define BAND_SKY_END    10'd140
`define BAND_RIM_END    10'd151
`define BAND_PANEL1_END 10'd243
`define BAND_STRIPE_END 10'd247
`define BAND_PANEL2_END 10'd338
`define BAND_BASE_END   10'd348
`define BAND_GAP_END    10'd351
`define BAND_LINE_END   10'd353
`define BAND_LOW_END    10'd472
`define BAND_FOOT_END   10'd479

`endif

//--- overlay_pkg.sv
`include "overlay_macros.svh"

package overlay_pkg;

  // Which text field covers a pixel
  typedef enum logic [4:0] {
    fieldNone,
    fieldHoursD,
    fieldHoursU,
    fieldMinutesD,
    fieldMinutesU,
    fieldSecondsD,
    fieldSecondsU,
    fieldWeekdayD,
    fieldWeekdayU,
    fieldDayD,
    fieldDayU,
    fieldMonthD,
    fieldMonthU,
    fieldYearD,
    fieldYearU,
    fieldWeekD,
    fieldWeekU,
    fieldLabel,       // Letters of "SEMANA"
    fieldYearPrefix   // Fixed "20"
  } fieldT;

  // Palette index
  typedef enum logic [`COLOR_W-1:0] {
    colorSky   = 3'd0,
    colorEdge  = 3'd1,
    colorText  = 3'd2,
    colorPanel = 3'd3
  } colorT;

endpackage

//--- pixelIntake.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module pixelIntake (
  input  logic                clk,
  input  logic                rstN,
  input  logic                inValid,
  output logic                inReady,
  input  logic [`COORD_W-1:0] pixelX,
  input  logic [`COORD_W-1:0] pixelY,
  input  logic [`CHAR_W-1:0]  hoursD, hoursU, minutesD, minutesU,
  input  logic [`CHAR_W-1:0]  secondsD, secondsU, weekdayD, weekdayU,
  input  logic [`CHAR_W-1:0]  dayD, dayU, monthD, monthU,
  input  logic [`CHAR_W-1:0]  yearD, yearU, weekD, weekU,
  input  logic                stageReady,          // Composer takes the held beat
  output logic                stageValid,
  output logic [`COORD_W-1:0] stagePixelX,
  output logic [`COORD_W-1:0] stagePixelY,
  output logic [`CHAR_W-1:0]  stageHoursD, stageHoursU, stageMinutesD, stageMinutesU,
  output logic [`CHAR_W-1:0]  stageSecondsD, stageSecondsU, stageWeekdayD, stageWeekdayU,
  output logic [`CHAR_W-1:0]  stageDayD, stageDayU, stageMonthD, stageMonthU,
  output logic [`CHAR_W-1:0]  stageYearD, stageYearU, stageWeekD, stageWeekU
);

  logic take;

  // A new beat may enter while the old one leaves
  assign inReady = !stageValid || stageReady;
  assign take    = inValid && inReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stageValid <= 1'b0;
    end else if (inReady) begin
      stageValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      stagePixelX   <= pixelX;
      stagePixelY   <= pixelY;
      stageHoursD   <= hoursD;
      stageHoursU   <= hoursU;
      stageMinutesD <= minutesD;
      stageMinutesU <= minutesU;
      stageSecondsD <= secondsD;
      stageSecondsU <= secondsU;
      stageWeekdayD <= weekdayD;
      stageWeekdayU <= weekdayU;
      stageDayD     <= dayD;
      stageDayU     <= dayU;
      stageMonthD   <= monthD;
      stageMonthU   <= monthU;
      stageYearD    <= yearD;
      stageYearU    <= yearU;
      stageWeekD    <= weekD;
      stageWeekU    <= weekU;
    end
  end

endmodule

//--- fieldLocator.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module fieldLocator (
  input  logic [`COORD_W-1:0] pixelX,
  input  logic [`COORD_W-1:0] pixelY,
  output overlay_pkg::fieldT  field,
  output logic [`CHAR_W-1:0]  labelChar
);

  logic [`COORD_W-1:0] labelOff;   // Column inside the label

  // Pixel inside a run of glyphs starting at column x0
  function automatic logic inWin(
    input logic [`COORD_W-1:0] x,
    input logic [`COORD_W-1:0] y,
    input logic [`COORD_W-1:0] x0,
    input logic [`COORD_W-1:0] glyphs,
    input logic [`COORD_W-1:0] yTop,
    input logic [`COORD_W-1:0] yBot
  );
    logic [`COORD_W-1:0] xEnd;
    xEnd = x0 + glyphs * `GLYPH_W;
    return (x >= x0) && (x < xEnd) && (y >= yTop) && (y <= yBot);
  endfunction

  // Left glyph of a pair holds the tens digit
  function automatic logic leftGlyph(
    input logic [`COORD_W-1:0] x,
    input logic [`COORD_W-1:0] x0
  );
    return x < x0 + `GLYPH_W;
  endfunction

  assign labelOff = pixelX - `LABEL_X;

  // First hit in table order wins
  always_comb begin
    field     = overlay_pkg::fieldNone;
    labelChar = `BLANK_CHAR;
    if (inWin(pixelX, pixelY, `HOURS_X, `PAIR_GLYPHS, `TIME_Y_TOP, `TIME_Y_BOT)) begin
      field = leftGlyph(pixelX, `HOURS_X) ? overlay_pkg::fieldHoursD
                                          : overlay_pkg::fieldHoursU;
    end else if (inWin(pixelX, pixelY, `MINUTES_X, `PAIR_GLYPHS, `TIME_Y_TOP, `TIME_Y_BOT)) begin
      field = leftGlyph(pixelX, `MINUTES_X) ? overlay_pkg::fieldMinutesD
                                            : overlay_pkg::fieldMinutesU;
    end else if (inWin(pixelX, pixelY, `SECONDS_X, `PAIR_GLYPHS, `TIME_Y_TOP, `TIME_Y_BOT)) begin
      field = leftGlyph(pixelX, `SECONDS_X) ? overlay_pkg::fieldSecondsD
                                            : overlay_pkg::fieldSecondsU;
    end else if (inWin(pixelX, pixelY, `LABEL_X, `LABEL_GLYPHS, `WEEK_Y_TOP, `WEEK_Y_BOT)) begin
      field = overlay_pkg::fieldLabel;
      case (labelOff[5:3])            // Glyph slot within "SEMANA"
        3'd0:    labelChar = 7'h53;   // S
        3'd1:    labelChar = 7'h45;   // E
        3'd2:    labelChar = 7'h4D;   // M
        3'd4:    labelChar = 7'h4E;   // N
        default: labelChar = 7'h41;   // A at slots 3 and 5
      endcase
    end else if (inWin(pixelX, pixelY, `WEEKNUM_X, `PAIR_GLYPHS, `WEEK_Y_TOP, `WEEK_Y_BOT)) begin
      field = leftGlyph(pixelX, `WEEKNUM_X) ? overlay_pkg::fieldWeekD
                                            : overlay_pkg::fieldWeekU;
    end else if (inWin(pixelX, pixelY, `PREFIX_X, `PAIR_GLYPHS, `YEAR_Y_TOP, `YEAR_Y_BOT)) begin
      field     = overlay_pkg::fieldYearPrefix;
      labelChar = leftGlyph(pixelX, `PREFIX_X) ? 7'h32 : 7'h30;   // "2" then "0"
    end else if (inWin(pixelX, pixelY, `YEAR_X, `PAIR_GLYPHS, `YEAR_Y_TOP, `YEAR_Y_BOT)) begin
      field = leftGlyph(pixelX, `YEAR_X) ? overlay_pkg::fieldYearD
                                         : overlay_pkg::fieldYearU;
    end else if (inWin(pixelX, pixelY, `DAY_X, `PAIR_GLYPHS, `DAY_Y_TOP, `DAY_Y_BOT)) begin
      field = leftGlyph(pixelX, `DAY_X) ? overlay_pkg::fieldDayD
                                        : overlay_pkg::fieldDayU;
    end else if (inWin(pixelX, pixelY, `WEEKDAY_X, `PAIR_GLYPHS, `DATE_Y_TOP, `DATE_Y_BOT)) begin
      field = leftGlyph(pixelX, `WEEKDAY_X) ? overlay_pkg::fieldWeekdayD
                                            : overlay_pkg::fieldWeekdayU;
    end else if (inWin(pixelX, pixelY, `MONTH_X, `PAIR_GLYPHS, `DATE_Y_TOP, `DATE_Y_BOT)) begin
      field = leftGlyph(pixelX, `MONTH_X) ? overlay_pkg::fieldMonthD
                                          : overlay_pkg::fieldMonthU;
    end
  end

endmodule

//--- bandClassifier.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module bandClassifier (
  input  logic [`COORD_W-1:0] pixelY,
  output overlay_pkg::colorT  bandColor
);

  // Bands are checked top to bottom so each test needs only the upper limit
  always_comb begin
    if (pixelY <= `BAND_SKY_END) begin
      bandColor = overlay_pkg::colorSky;
    end else if (pixelY <= `BAND_RIM_END) begin
      bandColor = overlay_pkg::colorEdge;    // Top rim of the panel
    end else if (pixelY <= `BAND_PANEL1_END) begin
      bandColor = overlay_pkg::colorPanel;
    end else if (pixelY <= `BAND_STRIPE_END) begin
      bandColor = overlay_pkg::colorEdge;    // Dark stripe across the panel
    end else if (pixelY <= `BAND_PANEL2_END) begin
      bandColor = overlay_pkg::colorPanel;
    end else if (pixelY <= `BAND_BASE_END) begin
      bandColor = overlay_pkg::colorEdge;
    end else if (pixelY <= `BAND_GAP_END) begin
      bandColor = overlay_pkg::colorSky;
    end else if (pixelY <= `BAND_LINE_END) begin
      bandColor = overlay_pkg::colorEdge;
    end else if (pixelY <= `BAND_LOW_END) begin
      bandColor = overlay_pkg::colorSky;
    end else if (pixelY <= `BAND_FOOT_END) begin
      bandColor = overlay_pkg::colorText;    // Bottom strip
    end else begin
      bandColor = overlay_pkg::colorSky;     // Off-screen rows
    end
  end

endmodule

//--- pixelComposer.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module pixelComposer (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stageValid,
  output logic                   stageReady,
  input  logic [`COORD_W-1:0]    pixelY,
  input  overlay_pkg::fieldT     field,
  input  logic [`CHAR_W-1:0]     labelChar,
  input  overlay_pkg::colorT     bandColor,
  input  logic [`CHAR_W-1:0]     stageHoursD, stageHoursU, stageMinutesD, stageMinutesU,
  input  logic [`CHAR_W-1:0]     stageSecondsD, stageSecondsU, stageWeekdayD, stageWeekdayU,
  input  logic [`CHAR_W-1:0]     stageDayD, stageDayU, stageMonthD, stageMonthU,
  input  logic [`CHAR_W-1:0]     stageYearD, stageYearU, stageWeekD, stageWeekU,
  output logic                   outValid,
  input  logic                   outReady,
  output logic [`ROM_ADDR_W-1:0] romAddr,
  output logic [`COLOR_W-1:0]    colorIdx,
  output logic                   bgSelect
);

  logic [`CHAR_W-1:0] charCode;
  logic               isBackground;
  logic               load;

  always_comb begin
    case (field)
      overlay_pkg::fieldHoursD:     charCode = stageHoursD;
      overlay_pkg::fieldHoursU:     charCode = stageHoursU;
      overlay_pkg::fieldMinutesD:   charCode = stageMinutesD;
      overlay_pkg::fieldMinutesU:   charCode = stageMinutesU;
      overlay_pkg::fieldSecondsD:   charCode = stageSecondsD;
      overlay_pkg::fieldSecondsU:   charCode = stageSecondsU;
      overlay_pkg::fieldWeekdayD:   charCode = stageWeekdayD;
      overlay_pkg::fieldWeekdayU:   charCode = stageWeekdayU;
      overlay_pkg::fieldDayD:       charCode = stageDayD;
      overlay_pkg::fieldDayU:       charCode = stageDayU;
      overlay_pkg::fieldMonthD:     charCode = stageMonthD;
      overlay_pkg::fieldMonthU:     charCode = stageMonthU;
      overlay_pkg::fieldYearD:      charCode = stageYearD;
      overlay_pkg::fieldYearU:      charCode = stageYearU;
      overlay_pkg::fieldWeekD:      charCode = stageWeekD;
      overlay_pkg::fieldWeekU:      charCode = stageWeekU;
      overlay_pkg::fieldLabel,
      overlay_pkg::fieldYearPrefix: charCode = labelChar;   // Fixed letters
      default:                      charCode = `BLANK_CHAR;
    endcase
  end

  assign isBackground = (field == overlay_pkg::fieldNone);

  // Output register is free when empty or being drained
  assign stageReady = !outValid || outReady;
  assign load       = stageReady && stageValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (stageReady) begin
      outValid <= stageValid;
    end
  end

  // Result holds while the sink stalls
  always_ff @(posedge clk) begin
    if (load) begin
      romAddr  <= {charCode, pixelY[`ROW_W-1:0]};   // Glyph then font row
      colorIdx <= isBackground ? bandColor : overlay_pkg::colorText;
      bgSelect <= isBackground;
    end
  end

endmodule

//--- overlayTop.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module overlayTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   inValid,
  output logic                   inReady,
  input  logic [`COORD_W-1:0]    pixelX,
  input  logic [`COORD_W-1:0]    pixelY,
  input  logic [`CHAR_W-1:0]     hoursD, hoursU, minutesD, minutesU,
  input  logic [`CHAR_W-1:0]     secondsD, secondsU, weekdayD, weekdayU,
  input  logic [`CHAR_W-1:0]     dayD, dayU, monthD, monthU,
  input  logic [`CHAR_W-1:0]     yearD, yearU, weekD, weekU,
  output logic                   outValid,
  input  logic                   outReady,
  output logic [`ROM_ADDR_W-1:0] romAddr,
  output logic [`COLOR_W-1:0]    colorIdx,
  output logic                   bgSelect
);

  // Intake stage to composer
  logic                stageValid;
  logic                stageReady;
  logic [`COORD_W-1:0] stagePixelX;
  logic [`COORD_W-1:0] stagePixelY;
  logic [`CHAR_W-1:0]  stageHoursD, stageHoursU, stageMinutesD, stageMinutesU;
  logic [`CHAR_W-1:0]  stageSecondsD, stageSecondsU, stageWeekdayD, stageWeekdayU;
  logic [`CHAR_W-1:0]  stageDayD, stageDayU, stageMonthD, stageMonthU;
  logic [`CHAR_W-1:0]  stageYearD, stageYearU, stageWeekD, stageWeekU;

  // Classifier results for the held pixel
  overlay_pkg::fieldT  field;
  logic [`CHAR_W-1:0]  labelChar;
  overlay_pkg::colorT  bandColor;

  pixelIntake uIntake (.*);   // All ports share names with the top level

  fieldLocator uLocator (
    .pixelX    (stagePixelX),
    .pixelY    (stagePixelY),
    .field     (field),
    .labelChar (labelChar)
  );

  bandClassifier uBands (
    .pixelY    (stagePixelY),
    .bandColor (bandColor)
  );

  // Row bits come from the held pixel, not the raw input
  pixelComposer uComposer (
    .pixelY (stagePixelY),
    .*
  );

endmodule

//--- overlay_chk.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module overlay_chk (
  input logic                   clk,
  input logic                   rstN,
  input logic                   outValid,
  input logic                   outReady,
  input logic [`ROM_ADDR_W-1:0] romAddr,
  input logic [`COLOR_W-1:0]    colorIdx,
  input logic                   bgSelect
);

  // Stalled output beat must not move
  holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
    (outValid && !outReady) |=> (outValid && $stable(romAddr) && $stable(colorIdx)
                                  && $stable(bgSelect)))
    else $error("output changed while the sink stalled");

  quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("outValid high during reset");

  // A valid beat always carries a defined address
  definedAddr: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> !$isunknown(romAddr))
    else $error("romAddr has unknown bits while outValid is high");

endmodule

bind overlayTop overlay_chk chk (
  .clk      (clk),
  .rstN     (rstN),
  .outValid (outValid),
  .outReady (outReady),
  .romAddr  (romAddr),
  .colorIdx (colorIdx),
  .bgSelect (bgSelect)
);

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- tb_overlay.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module tb_overlay;

  localparam int TOTAL_BEATS = 1 + 24 + 72 + 524 + 32 + 200;
  localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 200;
  localparam logic [47:0] LABEL_TEXT = "SEMANA";

  logic                   clk;
  logic                   rstN;
  logic                   inValid;
  logic                   inReady;
  logic [`COORD_W-1:0]    pixelX;
  logic [`COORD_W-1:0]    pixelY;
  logic [`CHAR_W-1:0]     codes [16];   // Same order as the digit ports
  logic                   outValid;
  logic                   outReady;
  logic [`ROM_ADDR_W-1:0] romAddr;
  logic [`COLOR_W-1:0]    colorIdx;
  logic                   bgSelect;

  // Text windows in table order
  int winX [10]    = '{295, 319, 342, 287, 343, 583, 599, 591, 575, 607};
  int winY [10]    = '{240, 240, 240, 16, 16, 418, 418, 434, 450, 450};
  int winN [10]    = '{2, 2, 2, 6, 2, 2, 2, 2, 2, 2};
  // Base -1 marks the label and -2 the year prefix
  int winBase [10] = '{0, 2, 4, -1, 14, -2, 12, 8, 6, 10};

  int timeX [6]  = '{295, 303, 319, 327, 342, 350};
  int dateX [18] = '{575, 583, 591, 599, 607, 615, 599, 607, 343, 351,
                     287, 295, 303, 311, 319, 327, 583, 591};
  int dateY [18] = '{450, 450, 434, 434, 450, 450, 418, 418, 16, 16,
                     16, 16, 16, 16, 16, 16, 418, 418};

  logic [14:0] expQ [$];   // {romAddr, colorIdx, bgSelect}
  int          cycQ [$];
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          testErr = 0;
  int unsigned rngState = 93005;
  int unsigned readyState = 93005;   // Own stream for the sink
  bit          streamMode = 0;
  bit          bpMode = 0;

  tbClock #(.PERIOD(40)) uClk (.clk(clk));

  overlayTop uut (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
    .pixelX(pixelX), .pixelY(pixelY),
    .hoursD(codes[0]), .hoursU(codes[1]), .minutesD(codes[2]), .minutesU(codes[3]),
    .secondsD(codes[4]), .secondsU(codes[5]), .weekdayD(codes[6]), .weekdayU(codes[7]),
    .dayD(codes[8]), .dayU(codes[9]), .monthD(codes[10]), .monthU(codes[11]),
    .yearD(codes[12]), .yearU(codes[13]), .weekD(codes[14]), .weekU(codes[15]),
    .outValid(outValid), .outReady(outReady), .romAddr(romAddr),
    .colorIdx(colorIdx), .bgSelect(bgSelect)
  );

  function automatic int unsigned rnd(inout int unsigned state);
    state = state * 1103515245 + 12345;
    return (state >> 16) & 32'h7fff;
  endfunction

  function automatic logic [2:0] bandOf(input int y);
    if (y <= 140) return 3'd0;
    else if (y <= 151) return 3'd1;
    else if (y <= 243) return 3'd3;
    else if (y <= 247) return 3'd1;   // Stripe
    else if (y <= 338) return 3'd3;
    else if (y <= 348) return 3'd1;
    else if (y <= 351) return 3'd0;
    else if (y <= 353) return 3'd1;
    else if (y <= 472) return 3'd0;
    else if (y <= 479) return 3'd2;
    else return 3'd0;
  endfunction

  function automatic logic [14:0] expectedOut(input int x, input int y);
    int         slot;
    logic       hit;
    logic [6:0] ch;
    hit = 1'b0;
    ch  = 7'h0A;
    for (int i = 0; i < 10; i++) begin
      if (!hit && x >= winX[i] && x < winX[i] + 8 * winN[i]
          && y >= winY[i] && y <= winY[i] + 15) begin
        hit  = 1'b1;
        slot = (x - winX[i]) / 8;
        if (winBase[i] == -1) ch = LABEL_TEXT[46 - 8 * slot -: 7];
        else if (winBase[i] == -2) ch = (slot == 0) ? 7'h32 : 7'h30;
        else ch = codes[winBase[i] + slot];
      end
    end
    return {ch, 4'(y), hit ? 3'd2 : bandOf(y), !hit};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expV,
                            input logic [31:0] actV);
    checks++;
    if (expV !== actV) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h at %0t",
               name, expV, actV, $time);
    end
  endtask

  task automatic sendBeat(input int x, input int y, input bit gaps);
    @(negedge clk);
    if (gaps) begin
      while (rnd(rngState) % 4 == 0) begin
        inValid = 1'b0;
        @(negedge clk);
      end
    end
    pixelX = 10'(x);
    pixelY = 10'(y);
    for (int i = 0; i < 16; i++) codes[i] = 7'(8'h30 + rnd(rngState) % 10);
    inValid = 1'b1;
    do @(posedge clk); while (!inReady);   // Held until taken
  endtask

  task automatic endTest(input int num, input string name);
    @(negedge clk);
    inValid = 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    $display("Test %0d %s finished with %0d mismatches", num, name, errors - testErr);
    testErr = errors;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, outputs stopped arriving", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Record each accepted beat with its expected result
  always @(posedge clk) begin
    if (rstN && inValid && inReady) begin
      expQ.push_back(expectedOut(int'(pixelX), int'(pixelY)));
      cycQ.push_back(cycle);
    end
  end

  always @(posedge clk) begin
    logic [14:0] e;
    int          c;
    if (rstN && outValid && outReady) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("Output beat arrived with no beat pending at %0t", $time);
      end else begin
        e = expQ.pop_front();
        c = cycQ.pop_front();
        checkValue("romAddr", 32'(e[14:4]), 32'(romAddr));
        checkValue("colorIdx", 32'(e[3:1]), 32'(colorIdx));
        checkValue("bgSelect", 32'(e[0]), 32'(bgSelect));
        if (streamMode) checkValue("latency", 32'(c + 2), 32'(cycle));
      end
    end
  end

  initial begin
    outReady = 1'b1;
    forever begin
      @(negedge clk);
      outReady = bpMode ? (rnd(readyState) % 4 != 0) : 1'b1;
    end
  end

  // inReady may drop only with both stages full and the sink stalled
  initial begin
    forever begin
      @(negedge clk);
      #5;
      if (rstN) checkValue("inReady", 32'(!(expQ.size() == 2 && !outReady)), 32'(inReady));
    end
  end

  initial begin
    int x;
    int y;
    rstN    = 1'b0;
    inValid = 1'b0;
    pixelX  = '0;
    pixelY  = '0;
    for (int i = 0; i < 16; i++) codes[i] = 7'h30;

    repeat (3) begin
      @(negedge clk);
      checkValue("outValid", 32'h0, 32'(outValid));
    end
    rstN = 1'b1;
    @(negedge clk);
    checkValue("outValid", 32'h0, 32'(outValid));
    pixelX  = 10'd10;
    pixelY  = 10'd100;
    inValid = 1'b1;
    @(posedge clk);
    checkValue("inReady", 32'h1, 32'(inReady));   // First beat goes straight in
    endTest(6, "reset");

    for (int g = 0; g < 6; g++) begin
      repeat (4) begin
        sendBeat(timeX[g] + int'(rnd(rngState) % 8), 240 + int'(rnd(rngState) % 16), 1'b0);
      end
    end
    endTest(1, "time digits");

    for (int g = 0; g < 18; g++) begin
      repeat (4) begin
        sendBeat(dateX[g] + int'(rnd(rngState) % 8), dateY[g] + int'(rnd(rngState) % 16),
                 1'b0);
      end
    end
    endTest(2, "date, week and labels");

    for (y = 0; y < 524; y++) sendBeat(10, y, 1'b0);   // Left of every field
    endTest(3, "background bands");

    streamMode = 1'b1;
    for (int i = 0; i < 32; i++) begin
      sendBeat(280 + int'(rnd(rngState) % 350), int'(rnd(rngState) % 480), 1'b0);
    end
    endTest(4, "streaming");
    streamMode = 1'b0;

    bpMode = 1'b1;
    for (int i = 0; i < 200; i++) begin
      x = 280 + int'(rnd(rngState) % 350);
      y = int'(rnd(rngState) % 480);
      sendBeat(x, y, 1'b1);
    end
    endTest(5, "back-pressure");
    bpMode = 1'b0;

    $display("Summary: %0d beats, %0d checks, %0d mismatches", TOTAL_BEATS, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
overlay_pkg.sv
pixelIntake.sv
fieldLocator.sv
bandClassifier.sv
pixelComposer.sv
overlayTop.sv
overlay_chk.sv
tbClock.sv
tb_overlay.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module tb_overlay -o Vtb_overlay
	./obj_dir/Vtb_overlay 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
